// ==== logic/rd_mon_cfg.svh ====
// ------------------------------
// Sizes for the AXI read monitor
// Include wherever a width or depth is needed
// ------------------------------
`ifndef RD_MON_CFG_SVH
`define RD_MON_CFG_SVH

`define RDM_ID_W       4
`define RDM_ADDR_W     32
`define RDM_DATA_W     32
`define RDM_MAX_TXN    4
`define RDM_TXN_IDX_W  2
`define RDM_CG_CNT_W   4
`define RDM_TMO_W      16
`define RDM_LAT_W      24
`define RDM_ACT_W      8
`define RDM_ERR_W      16
`define RDM_TXN_W      32

`endif

// ==== logic/axi_rd_pkg.sv ====
// ------------------------------
// AXI read channel types
// Response codes shared by the tracker, packer and testbench
// ------------------------------
package axi_rd_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } rresp_e;

    // Slave and decode errors both count as failures
    function automatic logic is_error(rresp_e resp);
        return (resp == SLVERR) || (resp == DECERR);
    endfunction

endpackage : axi_rd_pkg

// ==== logic/monitor_pkg.sv ====
// ------------------------------
// Monitor bus packet formats
// Packet kinds, the two 64-bit layouts and the event record
// ------------------------------
`include "rd_mon_cfg.svh"

package monitor_pkg;

    typedef enum logic [3:0] {
        PKT_ERROR   = 4'h0,
        PKT_COMPL   = 4'h1,
        PKT_TIMEOUT = 4'h3
    } pkt_type_e;

    typedef struct packed {
        pkt_type_e                pkt_type;
        logic [`RDM_ID_W-1:0]     id;
        logic [`RDM_LAT_W-1:0]    latency;
        logic [`RDM_ADDR_W-1:0]   addr;
    } compl_pkt_t;

    // Also used for timeouts, with resp left at OKAY
    typedef struct packed {
        pkt_type_e                pkt_type;
        logic [`RDM_ID_W-1:0]     id;
        axi_rd_pkg::rresp_e       resp;
        logic [`RDM_LAT_W-3:0]    rsvd;
        logic [`RDM_ADDR_W-1:0]   addr;
    } err_pkt_t;

    // Decode by the type field in the top nibble
    typedef union packed {
        compl_pkt_t compl;
        err_pkt_t   err;
    } mon_packet_u;

    typedef struct packed {
        pkt_type_e                kind;
        logic [`RDM_ID_W-1:0]     id;
        logic [`RDM_ADDR_W-1:0]   addr;
        axi_rd_pkg::rresp_e       resp;
        logic [`RDM_LAT_W-1:0]    latency;
    } mon_event_t;

endpackage : monitor_pkg

// ==== logic/mon_event_if.sv ====
// ------------------------------
// Event handshake from tracker to packer
// One event moves when valid and ready are both high
// ------------------------------
interface mon_event_if (
    input logic aclk
);

    logic                    valid;
    logic                    ready;
    monitor_pkg::mon_event_t data;

    modport producer (input aclk, output valid, output data, input ready);

    modport consumer (input aclk, input valid, input data, output ready);

endinterface : mon_event_if

// ==== logic/cg_idle_timer.sv ====
// ------------------------------
// Idle cycle counter for clock gating
// Counts while enabled, signals when the threshold is reached
// ------------------------------
`include "rd_mon_cfg.svh"

module cg_idle_timer (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      clear,
    input  logic                      count_en,
    input  logic [`RDM_CG_CNT_W-1:0]  threshold,
    output logic                      idle_done
);

    logic [`RDM_CG_CNT_W-1:0] cnt;

    always_ff @(posedge aclk) begin
        if (rst || clear) begin
            cnt <= '0;
        end else if (count_en && (cnt != '1)) begin
            // Saturate at all ones
            cnt <= cnt + 1'b1;
        end
    end

    assign idle_done = (cnt >= threshold);

endmodule : cg_idle_timer

// ==== logic/cg_state_ctrl.sv ====
// ------------------------------
// Clock-gating FSM
// Active, idle wait, gated; any activity wakes it
// ------------------------------
module cg_state_ctrl (
    input  logic aclk,
    input  logic rst,
    input  logic cg_enable,
    input  logic user_active,
    input  logic mem_active,
    input  logic idle_done,
    output logic timer_clear,
    output logic timer_count_en,
    output logic gating,
    output logic idle
);

    typedef enum logic [1:0] {
        ST_ACTIVE    = 2'd0,
        ST_IDLE_WAIT = 2'd1,
        ST_GATED     = 2'd2
    } cg_state_e;

    cg_state_e state;
    cg_state_e state_nxt;
    logic      activity;

    assign activity = user_active || mem_active;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_ACTIVE:    if (!activity && cg_enable) state_nxt = ST_IDLE_WAIT;
            ST_IDLE_WAIT: begin
                if (activity || !cg_enable) state_nxt = ST_ACTIVE;
                else if (idle_done)         state_nxt = ST_GATED;
            end
            ST_GATED:     if (activity || !cg_enable) state_nxt = ST_ACTIVE;
            default:      state_nxt = ST_ACTIVE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= ST_ACTIVE;
        end else begin
            state <= state_nxt;
        end
    end

    assign timer_clear    = (state == ST_ACTIVE);
    assign timer_count_en = (state == ST_IDLE_WAIT);
    assign gating         = (state == ST_GATED);
    assign idle           = (state != ST_ACTIVE);

endmodule : cg_state_ctrl

// ==== logic/rd_txn_tracker.sv ====
// ------------------------------
// Read pass-through with transaction tracking
// Raises completion, error and timeout events, keeps counters
// ------------------------------
`include "rd_mon_cfg.svh"

module rd_txn_tracker (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         gating,
    input  logic [`RDM_ID_W-1:0]         fub_arid,
    input  logic [`RDM_ADDR_W-1:0]       fub_araddr,
    input  logic [7:0]                   fub_arlen,
    input  logic                         fub_arvalid,
    output logic                         fub_arready,
    output logic [`RDM_ID_W-1:0]         fub_rid,
    output logic [`RDM_DATA_W-1:0]       fub_rdata,
    output axi_rd_pkg::rresp_e           fub_rresp,
    output logic                         fub_rlast,
    output logic                         fub_rvalid,
    input  logic                         fub_rready,
    output logic [`RDM_ID_W-1:0]         m_arid,
    output logic [`RDM_ADDR_W-1:0]       m_araddr,
    output logic [7:0]                   m_arlen,
    output logic                         m_arvalid,
    input  logic                         m_arready,
    input  logic [`RDM_ID_W-1:0]         m_rid,
    input  logic [`RDM_DATA_W-1:0]       m_rdata,
    input  axi_rd_pkg::rresp_e           m_rresp,
    input  logic                         m_rlast,
    input  logic                         m_rvalid,
    output logic                         m_rready,
    input  logic                         cfg_monitor_enable,
    input  logic [`RDM_TMO_W-1:0]        cfg_timeout_cycles,
    mon_event_if.producer                evt,
    output logic                         user_active,
    output logic                         mem_active,
    output logic                         busy,
    output logic [`RDM_ACT_W-1:0]        active_transactions,
    output logic [`RDM_ERR_W-1:0]        error_count,
    output logic [`RDM_TXN_W-1:0]        transaction_count
);

    logic [`RDM_MAX_TXN-1:0]     ent_vld;
    logic [`RDM_MAX_TXN-1:0]     ent_tmo;
    logic [`RDM_ID_W-1:0]        ent_id    [`RDM_MAX_TXN];
    logic [`RDM_ADDR_W-1:0]      ent_addr  [`RDM_MAX_TXN];
    logic [`RDM_LAT_W-1:0]       ent_start [`RDM_MAX_TXN];
    logic [`RDM_LAT_W-1:0]       ent_age   [`RDM_MAX_TXN];
    logic [`RDM_LAT_W-1:0]       now;
    logic [`RDM_LAT_W-1:0]       hit_age;
    logic [`RDM_TXN_IDX_W-1:0]   free_idx;
    logic [`RDM_TXN_IDX_W-1:0]   hit_idx;
    logic [`RDM_TXN_IDX_W-1:0]   tmo_idx;
    logic                        hit;
    logic                        tmo_hit;
    logic                        pass_ok;
    logic                        slot_free;
    logic                        r_open;
    logic                        ar_hs;
    logic                        r_done;
    logic                        new_cmpl;
    logic                        new_tmo;

    // AR stalls while gated or with every entry in use
    assign pass_ok     = !gating && !(&ent_vld);
    assign m_arvalid   = fub_arvalid && pass_ok;
    assign fub_arready = m_arready && pass_ok;
    assign m_arid      = fub_arid;
    assign m_araddr    = fub_araddr;
    assign m_arlen     = fub_arlen;

    // R stalls while gated or while the previous event waits for the packer
    assign slot_free  = !evt.valid || evt.ready;
    assign r_open     = !gating && slot_free;
    assign fub_rvalid = m_rvalid && r_open;
    assign m_rready   = fub_rready && r_open;
    assign fub_rid    = m_rid;
    assign fub_rdata  = m_rdata;
    assign fub_rresp  = m_rresp;
    assign fub_rlast  = m_rlast;

    assign ar_hs  = m_arvalid && m_arready;
    assign r_done = m_rvalid && m_rready && m_rlast;

    always_comb begin
        free_idx = '0;
        hit      = 1'b0;
        hit_idx  = '0;
        hit_age  = '0;
        tmo_hit  = 1'b0;
        tmo_idx  = '0;
        for (int i = 0; i < `RDM_MAX_TXN; i++) begin
            ent_age[i] = now - ent_start[i];
        end
        for (int i = `RDM_MAX_TXN - 1; i >= 0; i--) begin
            if (!ent_vld[i]) free_idx = `RDM_TXN_IDX_W'(i);
        end
        for (int i = 0; i < `RDM_MAX_TXN; i++) begin
            // Oldest entry wins when an ID is reused
            if (ent_vld[i] && (ent_id[i] == m_rid) && (!hit || ent_age[i] > hit_age)) begin
                hit     = 1'b1;
                hit_idx = `RDM_TXN_IDX_W'(i);
                hit_age = ent_age[i];
            end
            if (ent_vld[i] && !ent_tmo[i] && !tmo_hit &&
                (ent_age[i] > `RDM_LAT_W'(cfg_timeout_cycles))) begin
                tmo_hit = 1'b1;
                tmo_idx = `RDM_TXN_IDX_W'(i);
            end
        end
    end

    // Completion has priority, a timeout waits for a free slot
    assign new_cmpl = r_done && hit && cfg_monitor_enable;
    assign new_tmo  = tmo_hit && !new_cmpl && slot_free && !gating && cfg_monitor_enable;

    always_ff @(posedge aclk) begin
        if (rst) begin
            evt.valid         <= 1'b0;
            now               <= '0;
            ent_vld           <= '0;
            ent_tmo           <= '0;
            error_count       <= '0;
            transaction_count <= '0;
        end else begin
            if (evt.valid && evt.ready) evt.valid <= 1'b0;
            if (new_cmpl || new_tmo) evt.valid <= 1'b1;
            if (!gating) now <= now + 1'b1;
            if (ar_hs) begin
                ent_vld[free_idx] <= 1'b1;
                ent_tmo[free_idx] <= 1'b0;
            end
            if (r_done && hit) ent_vld[hit_idx] <= 1'b0;
            if (new_tmo) ent_tmo[tmo_idx] <= 1'b1;
            if (r_done) begin
                transaction_count <= transaction_count + 1'b1;
                if (axi_rd_pkg::is_error(m_rresp)) error_count <= error_count + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            ent_id[free_idx]    <= fub_arid;
            ent_addr[free_idx]  <= fub_araddr;
            ent_start[free_idx] <= now;
        end
        if (new_cmpl) begin
            evt.data.kind    <= axi_rd_pkg::is_error(m_rresp) ? monitor_pkg::PKT_ERROR
                                                              : monitor_pkg::PKT_COMPL;
            evt.data.id      <= m_rid;
            evt.data.addr    <= ent_addr[hit_idx];
            evt.data.resp    <= m_rresp;
            evt.data.latency <= hit_age;
        end else if (new_tmo) begin
            evt.data.kind    <= monitor_pkg::PKT_TIMEOUT;
            evt.data.id      <= ent_id[tmo_idx];
            evt.data.addr    <= ent_addr[tmo_idx];
            evt.data.resp    <= axi_rd_pkg::OKAY;
            evt.data.latency <= ent_age[tmo_idx];
        end
    end

    assign busy                = |ent_vld;
    assign active_transactions = `RDM_ACT_W'($countones(ent_vld));
    assign user_active         = fub_arvalid || fub_rready || busy;
    assign mem_active          = m_rvalid;

endmodule : rd_txn_tracker

// ==== logic/monbus_packer.sv ====
// ------------------------------
// Event to monitor bus packet
// Holds one packet until the bus takes it
// ------------------------------
module monbus_packer (
    input  logic                     aclk,
    input  logic                     rst,
    mon_event_if.consumer            evt,
    output logic                     monbus_valid,
    input  logic                     monbus_ready,
    output monitor_pkg::mon_packet_u monbus_packet
);

    monitor_pkg::mon_packet_u pkt_d;
    logic                     accept;

    // Room when empty or when the held packet leaves this cycle
    assign evt.ready = !monbus_valid || monbus_ready;
    assign accept    = evt.valid && evt.ready;

    always_comb begin
        pkt_d = '0;
        if (evt.data.kind == monitor_pkg::PKT_COMPL) begin
            pkt_d.compl.pkt_type = evt.data.kind;
            pkt_d.compl.id       = evt.data.id;
            pkt_d.compl.latency  = evt.data.latency;
            pkt_d.compl.addr     = evt.data.addr;
        end else begin
            pkt_d.err.pkt_type = evt.data.kind;
            pkt_d.err.id       = evt.data.id;
            pkt_d.err.resp     = evt.data.resp;
            pkt_d.err.addr     = evt.data.addr;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            monbus_valid <= 1'b0;
        end else if (accept) begin
            monbus_valid <= 1'b1;
        end else if (monbus_ready) begin
            monbus_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) monbus_packet <= pkt_d;
    end

endmodule : monbus_packer

// ==== logic/axi_rd_mon_cg.sv ====
// ------------------------------
// AXI read monitor with idle clock gating
// Sits between a read master (fub) and memory (m)
// ------------------------------
`include "rd_mon_cfg.svh"

module axi_rd_mon_cg (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         cfg_cg_enable,
    input  logic [`RDM_CG_CNT_W-1:0]     cfg_cg_idle_count,
    input  logic                         cfg_monitor_enable,
    input  logic [`RDM_TMO_W-1:0]        cfg_timeout_cycles,
    input  logic [`RDM_ID_W-1:0]         fub_arid,
    input  logic [`RDM_ADDR_W-1:0]       fub_araddr,
    input  logic [7:0]                   fub_arlen,
    input  logic                         fub_arvalid,
    output logic                         fub_arready,
    output logic [`RDM_ID_W-1:0]         fub_rid,
    output logic [`RDM_DATA_W-1:0]       fub_rdata,
    output axi_rd_pkg::rresp_e           fub_rresp,
    output logic                         fub_rlast,
    output logic                         fub_rvalid,
    input  logic                         fub_rready,
    output logic [`RDM_ID_W-1:0]         m_arid,
    output logic [`RDM_ADDR_W-1:0]       m_araddr,
    output logic [7:0]                   m_arlen,
    output logic                         m_arvalid,
    input  logic                         m_arready,
    input  logic [`RDM_ID_W-1:0]         m_rid,
    input  logic [`RDM_DATA_W-1:0]       m_rdata,
    input  axi_rd_pkg::rresp_e           m_rresp,
    input  logic                         m_rlast,
    input  logic                         m_rvalid,
    output logic                         m_rready,
    output logic                         monbus_valid,
    input  logic                         monbus_ready,
    output monitor_pkg::mon_packet_u     monbus_packet,
    output logic                         busy,
    output logic [`RDM_ACT_W-1:0]        active_transactions,
    output logic [`RDM_ERR_W-1:0]        error_count,
    output logic [`RDM_TXN_W-1:0]        transaction_count,
    output logic                         cg_gating,
    output logic                         cg_idle
);

    logic user_active;
    logic mem_active;
    logic timer_clear;
    logic timer_count_en;
    logic idle_done;

    mon_event_if i_evt_if (.aclk(aclk));

    // Channel, config and status ports share their names with the top
    rd_txn_tracker i_rd_txn_tracker (
        .gating (cg_gating),
        .evt    (i_evt_if),
        .*
    );

    monbus_packer i_monbus_packer (
        .aclk          (aclk),
        .rst           (rst),
        .evt           (i_evt_if),
        .monbus_valid  (monbus_valid),
        .monbus_ready  (monbus_ready),
        .monbus_packet (monbus_packet)
    );

    cg_state_ctrl i_cg_state_ctrl (
        .aclk           (aclk),
        .rst            (rst),
        .cg_enable      (cfg_cg_enable),
        .user_active    (user_active),
        .mem_active     (mem_active),
        .idle_done      (idle_done),
        .timer_clear    (timer_clear),
        .timer_count_en (timer_count_en),
        .gating         (cg_gating),
        .idle           (cg_idle)
    );

    cg_idle_timer i_cg_idle_timer (
        .aclk      (aclk),
        .rst       (rst),
        .clear     (timer_clear),
        .count_en  (timer_count_en),
        .threshold (cfg_cg_idle_count),
        .idle_done (idle_done)
    );

endmodule : axi_rd_mon_cg

// ==== verification/axi_rd_mon_cg_assertions.sv ====
// ------------------------------
// Handshake and gating properties
// Bound to the monitor top level by the bind below
// ------------------------------
`include "rd_mon_cfg.svh"

module axi_rd_mon_cg_assertions (
    input logic                      aclk,
    input logic                      rst,
    input logic                      cg_gating,
    input logic                      fub_arready,
    input logic                      m_rready,
    input logic                      m_arvalid,
    input logic [`RDM_ACT_W-1:0]     active_transactions,
    input logic                      monbus_valid,
    input logic                      monbus_ready,
    input monitor_pkg::mon_packet_u  monbus_packet
);
    timeunit 1ns;
    timeprecision 1ps;

    // Stalled packet must not change or drop
    monbus_hold: assert property (@(posedge aclk) disable iff (rst)
        monbus_valid && !monbus_ready |=> monbus_valid && $stable(monbus_packet))
        else $error("monitor packet changed while stalled");

    no_ready_gated: assert property (@(posedge aclk) disable iff (rst)
        cg_gating |-> !fub_arready && !m_rready)
        else $error("ready high while gated");

    no_ar_full: assert property (@(posedge aclk) disable iff (rst)
        active_transactions == `RDM_ACT_W'(`RDM_MAX_TXN) |-> !m_arvalid)
        else $error("AR issued with a full table");

endmodule : axi_rd_mon_cg_assertions

bind axi_rd_mon_cg axi_rd_mon_cg_assertions i_assertions (.*);

// ==== verification/axi_rd_mon_cg_tb.sv ====
// ------------------------------
// Testbench for the AXI read monitor
// Memory model, reads, packet checks, gating
// ------------------------------
`include "rd_mon_cfg.svh"

module axi_rd_mon_cg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAND = 12;
    localparam int N_ERR = 4;
    localparam int N_FILL = 5;
    localparam int N_BP = 12;
    localparam int TMO = 40;
    localparam int HOLD = 60;
    localparam int IDLE_CNT = 6;
    // Each read stays well under 30 cycles, plus timeout, gating and reset
    localparam int LIMIT = 8 + (N_RAND + N_ERR + N_FILL + N_BP) * 30 + HOLD + 40 + 200;

    logic                         aclk;
    logic                         rst;
    logic                         cfg_cg_enable;
    logic [`RDM_CG_CNT_W-1:0]     cfg_cg_idle_count;
    logic                         cfg_monitor_enable;
    logic [`RDM_TMO_W-1:0]        cfg_timeout_cycles;
    logic [`RDM_ID_W-1:0]         fub_arid;
    logic [`RDM_ADDR_W-1:0]       fub_araddr;
    logic [7:0]                   fub_arlen;
    logic                         fub_arvalid;
    logic                         fub_arready;
    logic [`RDM_ID_W-1:0]         fub_rid;
    logic [`RDM_DATA_W-1:0]       fub_rdata;
    axi_rd_pkg::rresp_e           fub_rresp;
    logic                         fub_rlast;
    logic                         fub_rvalid;
    logic                         fub_rready;
    logic [`RDM_ID_W-1:0]         m_arid;
    logic [`RDM_ADDR_W-1:0]       m_araddr;
    logic [7:0]                   m_arlen;
    logic                         m_arvalid;
    logic                         m_arready;
    logic [`RDM_ID_W-1:0]         m_rid;
    logic [`RDM_DATA_W-1:0]       m_rdata;
    axi_rd_pkg::rresp_e           m_rresp;
    logic                         m_rlast;
    logic                         m_rvalid;
    logic                         m_rready;
    logic                         monbus_valid;
    logic                         monbus_ready;
    monitor_pkg::mon_packet_u     monbus_packet;
    logic                         busy;
    logic [`RDM_ACT_W-1:0]        active_transactions;
    logic [`RDM_ERR_W-1:0]        error_count;
    logic [`RDM_TXN_W-1:0]        transaction_count;
    logic                         cg_gating;
    logic                         cg_idle;

    logic [31:0]                  rng;
    int                           cyc = 0;
    int                           hold_cycles;
    logic                         rand_ready;
    string                        cur_test;
    logic [`RDM_TXN_W-1:0]        exp_txn;
    logic [`RDM_TXN_W-1:0]        exp_err;
    monitor_pkg::mon_packet_u     exp_q[$];
    logic [3:0]                   ar_id_q[$];
    logic [31:0]                  ar_addr_q[$];

    axi_rd_mon_cg i_axi_rd_mon_cg (.*);

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Memory content and the SLVERR window at 0xE000_0000
    function automatic logic [31:0] ref_data(logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic in_err_range(logic [31:0] addr);
        return addr[31:28] == 4'hE;
    endfunction

    function automatic monitor_pkg::mon_packet_u ref_packet(monitor_pkg::pkt_type_e kind,
            logic [3:0] id, logic [31:0] addr, axi_rd_pkg::rresp_e resp, int lat);
        monitor_pkg::mon_packet_u p;
        p = '0;
        if (kind == monitor_pkg::PKT_COMPL) begin
            p.compl.pkt_type = kind;
            p.compl.id = id;
            p.compl.latency = 24'(lat);
            p.compl.addr = addr;
        end else begin
            p.err.pkt_type = kind;
            p.err.id = id;
            p.err.resp = resp;
            p.err.addr = addr;
        end
        return p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp,
            input logic [63:0] act);
        $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string what, input logic [`RDM_DATA_W-1:0] exp,
            input logic [`RDM_DATA_W-1:0] act);
        if (exp !== act) report_mismatch(what, 64'(exp), 64'(act));
    endtask

    task automatic check_resp(input string what, input axi_rd_pkg::rresp_e exp,
            input axi_rd_pkg::rresp_e act);
        if (exp !== act) report_mismatch(what, 64'(exp), 64'(act));
    endtask

    task automatic check_packet(input string what, input monitor_pkg::mon_packet_u exp,
            input monitor_pkg::mon_packet_u act);
        if (exp !== act) report_mismatch(what, exp, act);
    endtask

    task automatic check_count(input string what, input logic [`RDM_TXN_W-1:0] exp,
            input logic [`RDM_TXN_W-1:0] act);
        if (exp !== act) report_mismatch(what, 64'(exp), 64'(act));
    endtask

    task automatic do_read(input logic [3:0] id, input logic [31:0] addr);
        int ar_cyc;
        int r_cyc;
        logic err;
        err = in_err_range(addr);
        @(posedge aclk);
        #5;
        fub_arvalid = 1'b1;
        fub_arid = id;
        fub_araddr = addr;
        fub_rready = 1'b1;
        do @(negedge aclk); while (!fub_arready);
        ar_cyc = cyc;
        check_data("m_araddr", addr, m_araddr);
        check_data("m_arid", 32'(id), 32'(m_arid));
        check_count("m_arlen", 32'd0, 32'(m_arlen));
        @(posedge aclk);
        #5;
        fub_arvalid = 1'b0;
        if (hold_cycles > TMO) begin
            exp_q.push_back(ref_packet(monitor_pkg::PKT_TIMEOUT, id, addr,
                                       axi_rd_pkg::OKAY, 0));
        end
        do @(negedge aclk); while (!fub_rvalid);
        r_cyc = cyc;
        check_data("rdata", ref_data(addr), fub_rdata);
        check_data("rid", 32'(id), 32'(fub_rid));
        check_data("rlast", 32'd1, 32'(fub_rlast));
        check_resp("rresp", err ? axi_rd_pkg::SLVERR : axi_rd_pkg::OKAY, fub_rresp);
        check_count("active_transactions", 32'd1, 32'(active_transactions));
        check_count("busy", 32'd1, 32'(busy));
        exp_q.push_back(ref_packet(err ? monitor_pkg::PKT_ERROR : monitor_pkg::PKT_COMPL,
                                   id, addr, err ? axi_rd_pkg::SLVERR : axi_rd_pkg::OKAY,
                                   r_cyc - ar_cyc));
        exp_txn = exp_txn + 32'd1;
        if (err) exp_err = exp_err + 32'd1;
        @(posedge aclk);
        #5;
        fub_rready = 1'b0;
        @(negedge aclk);
        check_count("transaction_count", exp_txn, transaction_count);
        check_count("error_count", exp_err, `RDM_TXN_W'(error_count));
        check_count("busy after read", 32'd0, 32'(busy));
        check_count("active after read", 32'd0, 32'(active_transactions));
        check_count("cg_idle after read", 32'd0, 32'(cg_idle));
    endtask

    // Reads issued back to back against a slow memory, the last waits for a free entry
    task automatic fill_table();
        int n_ar;
        int n_r;
        logic stalled;
        n_ar = 0;
        n_r = 0;
        stalled = 1'b0;
        @(posedge aclk);
        #5;
        cfg_monitor_enable = 1'b0;
        fub_arvalid = 1'b1;
        fub_arid = 4'h0;
        fub_araddr = 32'h5000_0000;
        fub_rready = 1'b1;
        while (n_r < N_FILL) begin
            @(negedge aclk);
            if (fub_arvalid && active_transactions == `RDM_ACT_W'(`RDM_MAX_TXN)) begin
                check_count("arready with full table", 32'd0, 32'(fub_arready));
                stalled = 1'b1;
            end
            if (fub_arvalid && fub_arready) n_ar++;
            if (fub_rvalid) begin
                check_data("rdata", ref_data(32'h5000_0000 + 32'(n_r) * 32'h10), fub_rdata);
                check_data("rid", 32'(n_r), 32'(fub_rid));
                n_r++;
            end
            @(posedge aclk);
            #5;
            fub_arvalid = (n_ar < N_FILL);
            fub_arid = 4'(n_ar);
            fub_araddr = 32'h5000_0000 + 32'(n_ar) * 32'h10;
        end
        fub_rready = 1'b0;
        cfg_monitor_enable = 1'b1;
        if (!stalled) abort_run("The read table never filled up");
        exp_txn = exp_txn + 32'(N_FILL);
        @(negedge aclk);
        check_count("transaction_count", exp_txn, transaction_count);
    endtask

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) abort_run("Timeout: the tests did not finish in time");
    end

    // Memory slave, requests are queued here and answered in order
    always @(negedge aclk) begin
        if (m_arvalid && m_arready) begin
            ar_id_q.push_back(m_arid);
            ar_addr_q.push_back(m_araddr);
        end
    end

    initial begin : mem_slave
        logic [3:0] id;
        logic [31:0] addr;
        int delay;
        forever begin
            @(posedge aclk);
            if (ar_addr_q.size() != 0) begin
                id = ar_id_q.pop_front();
                addr = ar_addr_q.pop_front();
                delay = (hold_cycles >= 0) ? hold_cycles : int'(next_rand() % 8);
                repeat (delay) @(posedge aclk);
                #5;
                m_rvalid = 1'b1;
                m_rid = id;
                m_rdata = ref_data(addr);
                m_rresp = in_err_range(addr) ? axi_rd_pkg::SLVERR : axi_rd_pkg::OKAY;
                m_rlast = 1'b1;
                do @(negedge aclk); while (!m_rready);
                @(posedge aclk);
                #5;
                m_rvalid = 1'b0;
                m_rlast = 1'b0;
            end
        end
    end

    initial begin : monbus_ready_drive
        logic [31:0] r;
        forever begin
            @(posedge aclk);
            #5;
            r = next_rand();
            monbus_ready = rand_ready ? r[0] : 1'b1;
        end
    end

    initial begin : pkt_compare
        monitor_pkg::mon_packet_u exp;
        forever begin
            @(negedge aclk);
            if (!rst && monbus_valid && monbus_ready) begin
                if (exp_q.size() == 0) abort_run("Monitor packet seen with none expected");
                exp = exp_q.pop_front();
                check_packet("packet", exp, monbus_packet);
            end
        end
    end

    initial begin : main
        logic [31:0] r;
        int n;
        rng = 32'd60250;
        hold_cycles = -1;
        rand_ready = 1'b0;
        exp_txn = '0;
        exp_err = '0;
        cur_test = "reset";
        rst = 1'b1;
        cfg_cg_enable = 1'b0;
        cfg_cg_idle_count = `RDM_CG_CNT_W'(IDLE_CNT);
        cfg_monitor_enable = 1'b1;
        cfg_timeout_cycles = `RDM_TMO_W'(TMO);
        fub_arid = '0;
        fub_araddr = '0;
        fub_arlen = '0;
        fub_arvalid = 1'b0;
        fub_rready = 1'b0;
        m_arready = 1'b1;
        m_rid = '0;
        m_rdata = '0;
        m_rresp = axi_rd_pkg::OKAY;
        m_rlast = 1'b0;
        m_rvalid = 1'b0;
        monbus_ready = 1'b1;
        repeat (8) @(posedge aclk);
        #5;
        rst = 1'b0;

        cur_test = "random_reads";
        repeat (N_RAND) begin
            r = next_rand();
            do_read(r[3:0], {4'h1, r[27:2], 2'b00});
        end

        cur_test = "slverr_reads";
        repeat (N_ERR) begin
            r = next_rand();
            do_read(r[7:4], {4'hE, r[27:2], 2'b00});
        end

        cur_test = "table_full";
        hold_cycles = 4;
        fill_table();
        hold_cycles = -1;

        cur_test = "timeout";
        hold_cycles = HOLD;
        do_read(4'h9, 32'h2000_0040);
        hold_cycles = -1;

        cur_test = "idle_gating";
        @(posedge aclk);
        #5;
        cfg_cg_enable = 1'b1;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            @(negedge aclk);
            check_count("cg_idle", 32'd1, 32'(cg_idle));
            if (n > 50) abort_run("cg_gating never rose with the design idle");
        end while (!cg_gating);
        // One cycle to leave active and one to enter gated, around the idle count
        check_count("gating delay", 32'(IDLE_CNT + 2), 32'(n));
        do_read(4'h3, 32'h3000_0100);

        cur_test = "backpressure";
        rand_ready = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            r = next_rand();
            do_read(r[3:0], {(i % 3 == 2) ? 4'hE : 4'h4, r[27:2], 2'b00});
        end
        while (exp_q.size() != 0 || monbus_valid) @(negedge aclk);
        rand_ready = 1'b0;
        check_count("final transaction_count", exp_txn, transaction_count);
        check_count("final error_count", exp_err, `RDM_TXN_W'(error_count));
        $display("*** PASSED ***");
        $finish;
    end

endmodule : axi_rd_mon_cg_tb

// ==== axi_rd_mon_cg.f ====
+incdir+logic
logic/axi_rd_pkg.sv
logic/monitor_pkg.sv
logic/mon_event_if.sv
logic/cg_idle_timer.sv
logic/cg_state_ctrl.sv
logic/rd_txn_tracker.sv
logic/monbus_packer.sv
logic/axi_rd_mon_cg.sv
verification/axi_rd_mon_cg_assertions.sv
verification/axi_rd_mon_cg_tb.sv

// ==== Makefile ====
TOP = axi_rd_mon_cg_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f axi_rd_mon_cg.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q 'PASSED' sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
